//--- all.f
source/cart_load_pkg.sv
source/load_bus_if.sv
source/load_port.sv
source/cheat_code_loader.sv
source/region_detect.sv
source/cart_quirk_lookup.sv
source/cart_load_top.sv
tests/tb_cart_load.sv

//--- Makefile
# Verilator flow for the cartridge load path

VERILATOR ?= verilator
TOP       ?= tb_cart_load
RTL_TOP   ?= cart_load_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
LINT_OPTS ?= --lint-only --timing
SIM_OPTS  ?= --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_OPTS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_cart_load.sv
// cartridge load testbench: random loader traffic checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_cart_load;
	import cart_load_pkg::*;

	localparam int ADDR_WIDTH  = 25;
	localparam int CLK_PERIOD  = 100;
	localparam int IMAGE_WORDS = 600;
	localparam int CHEAT_CODES = 6;
	// header downloads run from 0x180 up to 0x200
	localparam int HDR_WORDS   = 65;
	localparam int HDR_RUNS    = 8 + 16 + 2;
	localparam int TOTAL_WORDS = IMAGE_WORDS + CHEAT_CODES * 8 + HDR_RUNS * HDR_WORDS;

	logic                  clk_sys;
	logic                  reset;
	logic                  loading;
	logic [7:0]            load_index;
	logic                  load_wr;
	logic [ADDR_WIDTH-1:0] load_addr;
	load_word_t            load_data;
	logic                  load_wait;
	logic [ADDR_WIDTH-1:0] sdram_addr;
	load_word_t            sdram_data;
	logic                  sdram_req;
	logic                  sdram_ack;
	cheat_code_t           cheat_code;
	logic                  cheat_available_reset;
	logic                  region_j;
	logic                  region_u;
	logic                  region_e;
	logic                  header_ready;
	quirk_flags_t          quirks;
	logic                  gun_type;
	logic [7:0]            gun_sensor_delay;

	logic [31:0]           seed;
	int                    checks = 0;
	int                    errors = 0;
	int                    err_mark = 0;
	int                    load_pulses = 0;
	int                    avail_pulses = 0;
	logic [63:0]           table_ids [10];
	// expected and observed SDRAM writes, in order
	logic [ADDR_WIDTH-1:0] exp_addr_q[$];
	logic [ADDR_WIDTH-1:0] rec_addr_q[$];
	logic [15:0]           exp_data_q[$];
	logic [15:0]           rec_data_q[$];

	cart_load_top #(.ADDR_WIDTH(ADDR_WIDTH)) cart_load_top_i (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////
	// reference model

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// J first, then U, then any code from 0 to Z
	function automatic logic [2:0] region_model(input logic [7:0] c);
		if (c == "J") return 3'b100;
		if (c == "U") return 3'b010;
		if ((c >= "0") && (c <= "Z")) return 3'b001;
		return 3'b000;
	endfunction

	// {sram, eeprom, noram, fifo, fmbusy, gun type, sensor delay}
	function automatic logic [13:0] quirk_model(input logic [63:0] id);
		logic [4:0] q;
		logic       g;
		logic [7:0] d;
		q = 5'b00000;
		g = 1'b0;
		d = 8'd44;
		if ((id == "T-081276") || (id == "T-81406 ")) q = 5'b10000;
		else if ((id == "MK-1215 ") || (id == "G-4060  ")) q = 5'b01000;
		else if (id == "T-113016") q = 5'b00100;
		else if (id == "T-89016 ") q = 5'b00010;
		else if (id == "T-35036 ") q = 5'b00001;
		else if (id == "MK-1533 ") d = 8'd100;
		else if (id == "T-95096-") begin
			g = 1'b1;
			d = 8'd52;
		end else if (id == "T-95136-") begin
			g = 1'b1;
			d = 8'd30;
		end
		return {q, g, d};
	endfunction

	// header byte from J, U, digits, letters or anything
	function automatic logic [7:0] region_byte(input logic [31:0] r);
		case (r[31:16] % 5)
			0: return "J";
			1: return "U";
			2: return 8'h30 + r[15:0] % 10;
			3: return 8'h41 + r[15:0] % 26;
			default: return r[7:0];
		endcase
	endfunction

	task automatic check_eq(input logic [159:0] got, input logic [159:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %-8s finished, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	////////////////////////////////////////
	// loader side stimulus

	task automatic strobe(input logic [ADDR_WIDTH-1:0] addr, input logic [15:0] data);
		load_wr        = 1'b1;
		load_addr      = addr;
		load_data.word = data;
		@(negedge clk_sys);
		load_wr = 1'b0;
	endtask

	// cheat files use the all-ones slot, cartridges any other
	task automatic start_download(input logic code);
		seed = lcg(seed);
		loading    = 1'b1;
		load_index = code ? CODE_MENU_INDEX : ((seed[31:24] == 8'hFF) ? 8'h00 : seed[31:24]);
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		while (load_wait) @(negedge clk_sys);
		loading = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	// back-pressure honoured before each strobe
	task automatic send_cart_word(input logic [ADDR_WIDTH-1:0] addr, input logic [15:0] data);
		while (load_wait) @(negedge clk_sys);
		check_eq(sdram_ack, sdram_req, "ack not caught up when load_wait fell");
		exp_addr_q.push_back(addr);
		exp_data_q.push_back({data[7:0], data[15:8]});
		strobe(addr, data);
		check_eq(load_wait, 1'b1, "load_wait after cart strobe");
	endtask

	task automatic send_code_word(input logic [ADDR_WIDTH-1:0] addr, input logic [15:0] data);
		strobe(addr, data);
		check_eq(cheat_available_reset, addr == 0, "cheat_available_reset");
		check_eq(load_wait, 1'b0, "load_wait on cheat word");
	endtask

	task automatic compare_sdram_log();
		int i;
		check_eq(rec_addr_q.size(), exp_addr_q.size(), "sdram write count");
		for (i = 0; (i < exp_addr_q.size()) && (i < rec_addr_q.size()); i++) begin
			check_eq(rec_addr_q[i], exp_addr_q[i], "sdram_addr");
			check_eq(rec_data_q[i], exp_data_q[i], "sdram_data byte swap");
		end
		exp_addr_q.delete();
		exp_data_q.delete();
		rec_addr_q.delete();
		rec_data_q.delete();
	endtask

	task automatic random_id(output logic [63:0] id);
		int k;
		for (k = 0; k < 8; k++) begin
			seed = lcg(seed);
			id[8*k +: 8] = 8'h20 + seed[31:16] % 95;
		end
	endtask

	task automatic random_region(output logic [15:0] w_a, output logic [15:0] w_b);
		seed = lcg(seed);
		w_a[15:8] = region_byte(seed);
		seed = lcg(seed);
		w_a[7:0] = region_byte(seed);
		seed = lcg(seed);
		w_b = {seed[7:0], region_byte(seed)};
	endtask

	// one cartridge header with ID and region words, then all flag checks
	task automatic run_download(input logic [63:0] id, input logic [15:0] w_a,
			input logic [15:0] w_b);
		logic [ADDR_WIDTH-1:0] a;
		logic [15:0]           w;
		logic [2:0]            exp_region;
		logic [13:0]           exp_q;
		int                    i;
		exp_region = region_model(w_a[7:0]) | region_model(w_a[15:8]) | region_model(w_b[7:0]);
		exp_q      = quirk_model(id);
		start_download(1'b0);
		for (i = 0; i < HDR_WORDS; i++) begin
			a = 'h180 + 2 * i;
			seed = lcg(seed);
			w = seed[31:16];
			case (a)
				'h182: w[15:8] = id[63:56];
				'h184: w = {id[47:40], id[55:48]};
				'h186: w = {id[31:24], id[39:32]};
				'h188: w = {id[15:8], id[23:16]};
				'h18A: w[7:0] = id[7:0];
				'h1F0: w = w_a;
				'h1F2: w = w_b;
				'h200: check_eq(header_ready, 1'b0, "header_ready before 0x200");
				default: ;
			endcase
			send_cart_word(a, w);
		end
		@(negedge clk_sys);
		check_eq(header_ready, 1'b1, "header_ready after 0x200");
		end_download();
		check_eq(header_ready, 1'b0, "header_ready after loading fell");
		check_eq({region_j, region_u, region_e}, exp_region, "region flags");
		check_eq(quirks, exp_q[13:9], "quirk flags");
		check_eq(gun_type, exp_q[8], "gun_type");
		check_eq(gun_sensor_delay, exp_q[7:0], "gun_sensor_delay");
		compare_sdram_log();
	endtask

	////////////////////////////////////////
	// SDRAM responder and pulse monitors

	initial begin : sdram_responder
		logic [31:0] ack_seed;
		int          delay;
		sdram_ack = 1'b0;
		ack_seed  = 32'h1953_0849 ^ 32'h0000_FFFF;
		forever begin
			@(negedge clk_sys);
			// a new request shows up as req differing from ack
			if (!reset && (sdram_req != sdram_ack)) begin
				rec_addr_q.push_back(sdram_addr);
				rec_data_q.push_back(sdram_data.word);
				ack_seed = lcg(ack_seed);
				delay    = ack_seed[31:16] % 8;
				repeat (delay) @(negedge clk_sys);
				sdram_ack = sdram_req;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!reset && cheat_code.load) load_pulses++;
		if (!reset && cheat_available_reset) avail_pulses++;
	end

	initial begin : watchdog
		#(TOTAL_WORDS * 20 * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", TOTAL_WORDS * 20);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////
	// test sequence

	initial begin : main
		int          i;
		int          j;
		int          c;
		int          tmp;
		int          order [7];
		int          base;
		logic [15:0] h [8];
		logic [63:0] id;
		logic [15:0] w_a;
		logic [15:0] w_b;
		clk_sys    = 1'b0;
		reset      = 1'b1;
		loading    = 1'b0;
		load_index = 8'h00;
		load_wr    = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		seed       = 32'h1953_0849;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		// write pacing over a random image
		start_download(1'b0);
		for (i = 0; i < IMAGE_WORDS; i++) begin
			seed = lcg(seed);
			send_cart_word(i * 2, seed[31:16]);
		end
		end_download();
		compare_sdram_log();
		finish_test("pacing");

		// cheat codes, offsets shuffled with 14 kept last
		start_download(1'b1);
		for (c = 0; c < CHEAT_CODES; c++) begin
			for (i = 0; i < 8; i++) begin
				seed = lcg(seed);
				h[i] = seed[31:16];
			end
			for (i = 0; i < 7; i++) order[i] = i;
			for (i = 6; i > 0; i--) begin
				seed = lcg(seed);
				j = seed[31:16] % (i + 1);
				tmp = order[i];
				order[i] = order[j];
				order[j] = tmp;
			end
			base = load_pulses;
			for (i = 0; i < 7; i++) send_code_word(c * 16 + order[i] * 2, h[order[i]]);
			send_code_word(c * 16 + 14, h[7]);
			@(negedge clk_sys);
			@(negedge clk_sys);
			check_eq(load_pulses - base, 1, "load pulses per code");
			check_eq(cheat_code[127:0], {h[1], h[0], h[3], h[2], h[5], h[4], h[7], h[6]},
				"cheat code packing");
		end
		end_download();
		check_eq(avail_pulses, 1, "cheat_available_reset pulse count");
		finish_test("cheat");

		// region scan with random IDs
		for (i = 0; i < 8; i++) begin
			random_id(id);
			random_region(w_a, w_b);
			run_download(id, w_a, w_b);
		end
		finish_test("region");

		// every table entry, then some unknown IDs
		table_ids = '{"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "T-113016",
			"T-89016 ", "T-35036 ", "MK-1533 ", "T-95096-", "T-95136-"};
		for (i = 0; i < 16; i++) begin
			if (i < 10) id = table_ids[i];
			else random_id(id);
			random_region(w_a, w_b);
			run_download(id, w_a, w_b);
		end
		finish_test("quirk");

		// flagged cart followed by a neutral one
		run_download("T-113016", {"J", "U"}, {8'h00, "E"});
		run_download("T-00000 ", 16'h2020, 16'h2020);
		check_eq({region_j, region_u, region_e, quirks}, '0, "flags left from last download");
		finish_test("restart");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/cart_load_top.sv
// cartridge load top: load port, cheat loader, region scan and quirk table on one load bus
`timescale 1ns/1ps
`default_nettype none

module cart_load_top #(
	parameter int ADDR_WIDTH = 25
) (
	input  wire                              clk_sys,
	input  wire                              reset,
	// flash-side loader
	input  wire                              loading,
	input  wire [7:0]                        load_index,
	input  wire                              load_wr,
	input  wire [ADDR_WIDTH-1:0]             load_addr,
	input  wire cart_load_pkg::load_word_t   load_data,
	output wire                              load_wait,
	// SDRAM write port
	output wire [ADDR_WIDTH-1:0]             sdram_addr,
	output cart_load_pkg::load_word_t        sdram_data,
	output wire                              sdram_req,
	input  wire                              sdram_ack,
	// to the console core
	output cart_load_pkg::cheat_code_t       cheat_code,
	output wire                              cheat_available_reset,
	output wire                              region_j,
	output wire                              region_u,
	output wire                              region_e,
	output wire                              header_ready,
	output cart_load_pkg::quirk_flags_t      quirks,
	output wire                              gun_type,
	output wire [7:0]                        gun_sensor_delay
);

	load_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) load_bus ();

	////////////////////////////////////////
	// front end

	load_port #(.ADDR_WIDTH(ADDR_WIDTH)) load_port_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.loading    (loading),
		.load_index (load_index),
		.load_wr    (load_wr),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_wait  (load_wait),
		.sdram_addr (sdram_addr),
		.sdram_data (sdram_data),
		.sdram_req  (sdram_req),
		.sdram_ack  (sdram_ack),
		.bus        (load_bus.src)
	);

	////////////////////////////////////////
	// parsers

	cheat_code_loader cheat_code_loader_i (
		.clk_sys               (clk_sys),
		.reset                 (reset),
		.bus                   (load_bus.sink),
		.cheat_code            (cheat_code),
		.cheat_available_reset (cheat_available_reset)
	);

	region_detect region_detect_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.loading      (loading),
		.bus          (load_bus.sink),
		.region_j     (region_j),
		.region_u     (region_u),
		.region_e     (region_e),
		.header_ready (header_ready)
	);

	cart_quirk_lookup cart_quirk_lookup_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.bus              (load_bus.sink),
		.quirks           (quirks),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay)
	);

endmodule

`default_nettype wire

//--- source/cart_quirk_lookup.sv
// cart quirk lookup: collects the header serial number and maps it to quirk and gun settings
`timescale 1ns/1ps
`default_nettype none

module cart_quirk_lookup (
	input  wire                           clk_sys,
	input  wire                           reset,
	load_bus_if.sink                      bus,
	output cart_load_pkg::quirk_flags_t   quirks,
	output logic                          gun_type,
	output logic [7:0]                    gun_sensor_delay
);
	import cart_load_pkg::*;

	logic [63:0]  cart_id;
	quirk_flags_t id_flags;
	logic         id_gun_type;
	logic [7:0]   id_delay;
	logic         id_decide;

	////////////////////////////////////////
	// serial number gather

	// header words are big endian, so middle words get swapped
	always_ff @(posedge clk_sys) begin
		if (bus.cart_wr) begin
			if (bus.addr == ID_FIRST)
				cart_id[63:56] <= bus.word.bytes.hi_byte;
			if (bus.addr == ID_FIRST + 2)
				cart_id[55:40] <= {bus.word.bytes.lo_byte, bus.word.bytes.hi_byte};
			if (bus.addr == ID_FIRST + 4)
				cart_id[39:24] <= {bus.word.bytes.lo_byte, bus.word.bytes.hi_byte};
			if (bus.addr == ID_FIRST + 6)
				cart_id[23:8] <= {bus.word.bytes.lo_byte, bus.word.bytes.hi_byte};
			if (bus.addr == ID_LAST)
				cart_id[7:0] <= bus.word.bytes.lo_byte;
		end
	end

	////////////////////////////////////////
	// table

	always_comb begin
		id_flags    = '0;
		id_gun_type = 1'b0;
		id_delay    = GUN_DELAY_DEFAULT;
		case (cart_id)
			// battery RAM mapped where the header does not say so
			"T-081276": id_flags.sram   = 1'b1;
			"T-81406 ": id_flags.sram   = 1'b1;
			// serial EEPROM saves
			"MK-1215 ": id_flags.eeprom = 1'b1;
			"G-4060  ": id_flags.eeprom = 1'b1;
			// copy protection expects no RAM
			"T-113016": id_flags.noram  = 1'b1;
			"T-89016 ": id_flags.fifo   = 1'b1;
			"T-35036 ": id_flags.fmbusy = 1'b1;
			// light gun titles, menacer style unless noted
			"MK-1533 ": id_delay = 8'd100;
			"T-95096-": begin
				// justifier
				id_gun_type = 1'b1;
				id_delay    = 8'd52;
			end
			"T-95136-": begin
				id_gun_type = 1'b1;
				id_delay    = 8'd30;
			end
			default: ;
		endcase
	end

	assign id_decide = bus.cart_wr && (bus.addr == ID_DECIDE);

	// quirks only ever set here, cleared by a new download
	// gun settings follow the latest lookup
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			quirks           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= GUN_DELAY_DEFAULT;
		end else begin
			if (bus.cart_start) quirks <= '0;
			if (id_decide) begin
				quirks           <= quirks | id_flags;
				gun_type         <= id_gun_type;
				gun_sensor_delay <= id_delay;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/region_detect.sv
// region detect: scans the ROM header region field for J, U and export letters
`timescale 1ns/1ps
`default_nettype none

module region_detect (
	input  wire      clk_sys,
	input  wire      reset,
	input  wire      loading,
	load_bus_if.sink bus,
	output logic     region_j,
	output logic     region_u,
	output logic     region_e,
	output logic     header_ready
);
	import cart_load_pkg::*;

	logic [2:0] region_q;
	logic [2:0] hit;
	logic       loading_q;

	// one region letter, J beats U beats any other printable code
	function automatic logic [2:0] region_hit(input logic [7:0] c);
		logic [2:0] r;
		r = 3'b000;
		if (c == "J") r[2] = 1'b1;
		else if (c == "U") r[1] = 1'b1;
		else if ((c >= "0") && (c <= "Z")) r[0] = 1'b1;
		return r;
	endfunction

	// low byte of both region words, high byte only of the first
	always_comb begin
		hit = 3'b000;
		if (bus.cart_wr) begin
			if ((bus.addr == HDR_REGION_A) || (bus.addr == HDR_REGION_B))
				hit = hit | region_hit(bus.word.bytes.lo_byte);
			if (bus.addr == HDR_REGION_A)
				hit = hit | region_hit(bus.word.bytes.hi_byte);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_q     <= 3'b000;
			header_ready <= 1'b0;
			loading_q    <= 1'b0;
		end else begin
			loading_q <= loading;
			// flags collect over the whole header, new download starts clean
			region_q  <= (bus.cart_start ? 3'b000 : region_q) | hit;
			if (bus.cart_wr && (bus.addr == HDR_END)) header_ready <= 1'b1;
			// end of download wins over a late header word
			if (loading_q && !loading) header_ready <= 1'b0;
		end
	end

	assign region_j = region_q[2];
	assign region_u = region_q[1];
	assign region_e = region_q[0];

endmodule

`default_nettype wire

//--- source/cheat_code_loader.sv
// cheat code loader: packs eight cheat half-words into one code and pulses its load bit
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader (
	input  wire                          clk_sys,
	input  wire                          reset,
	load_bus_if.sink                     bus,
	output cart_load_pkg::cheat_code_t   cheat_code,
	output logic                         cheat_available_reset
);
	import cart_load_pkg::*;

	logic        load_q;
	logic [31:0] flags_q;
	logic [31:0] address_q;
	logic [31:0] compare_q;
	logic [31:0] replace_q;

	// load strobe, high for the cycle after the last half-word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q <= 1'b0;
		end else begin
			load_q <= bus.code_wr && (bus.addr[3:0] == CHEAT_LAST_OFFSET);
		end
	end

	// low half first, then high half, for each field
	// odd offsets fall through
	always_ff @(posedge clk_sys) begin
		if (bus.code_wr) begin
			case (bus.addr[3:0])
				4'd0:              flags_q[15:0]    <= bus.word.word;
				4'd2:              flags_q[31:16]   <= bus.word.word;
				4'd4:              address_q[15:0]  <= bus.word.word;
				4'd6:              address_q[31:16] <= bus.word.word;
				4'd8:              compare_q[15:0]  <= bus.word.word;
				4'd10:             compare_q[31:16] <= bus.word.word;
				4'd12:             replace_q[15:0]  <= bus.word.word;
				CHEAT_LAST_OFFSET: replace_q[31:16] <= bus.word.word;
				default: ;
			endcase
		end
	end

	assign cheat_code.load    = load_q;
	assign cheat_code.flags   = flags_q;
	assign cheat_code.address = address_q;
	assign cheat_code.compare = compare_q;
	assign cheat_code.replace = replace_q;

	// first word of a cheat file drops the old code list
	assign cheat_available_reset = bus.code_wr && (bus.addr == '0);

endmodule

`default_nettype wire

//--- source/load_port.sv
// load port: splits loader words into cart and cheat traffic and paces cart writes to SDRAM
`timescale 1ns/1ps
`default_nettype none

module load_port #(
	parameter int ADDR_WIDTH = 25
) (
	input  wire                              clk_sys,
	input  wire                              reset,
	// loader side
	input  wire                              loading,
	input  wire [7:0]                        load_index,
	input  wire                              load_wr,
	input  wire [ADDR_WIDTH-1:0]             load_addr,
	input  wire cart_load_pkg::load_word_t   load_data,
	output logic                             load_wait,
	// SDRAM write port
	output logic [ADDR_WIDTH-1:0]            sdram_addr,
	output cart_load_pkg::load_word_t        sdram_data,
	output logic                             sdram_req,
	input  wire                              sdram_ack,
	// to the parsers
	load_bus_if.src                          bus
);
	import cart_load_pkg::*;

	logic code_index;
	logic cart_download;
	logic code_download;
	logic cart_dl_q;

	// cheat files arrive on the all-ones menu slot, everything else is ROM
	assign code_index    = (load_index == CODE_MENU_INDEX);
	assign cart_download = loading & ~code_index;
	assign code_download = loading & code_index;

	////////////////////////////////////////
	// strobes and write handshake

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q      <= 1'b0;
			bus.cart_start <= 1'b0;
			bus.cart_wr    <= 1'b0;
			bus.code_wr    <= 1'b0;
			sdram_req      <= 1'b0;
			load_wait      <= 1'b0;
		end else begin
			cart_dl_q      <= cart_download;
			bus.cart_start <= cart_download & ~cart_dl_q;
			bus.cart_wr    <= load_wr & cart_download;
			bus.code_wr    <= load_wr & code_download;
			// toggle request, hold the loader until ack catches up
			if (load_wr && cart_download) begin
				sdram_req <= ~sdram_req;
				load_wait <= 1'b1;
			end else if (load_wait && (sdram_req == sdram_ack)) begin
				load_wait <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// payload

	always_ff @(posedge clk_sys) begin
		if (load_wr) begin
			bus.addr <= load_addr;
			bus.word <= load_data;
		end
		// SDRAM wants the other byte order
		if (load_wr && cart_download) begin
			sdram_addr <= load_addr;
			sdram_data <= {load_data.bytes.lo_byte, load_data.bytes.hi_byte};
		end
	end

endmodule

`default_nettype wire

//--- source/load_bus_if.sv
// load bus: one classified loader word broadcast from the load port to the parsers
`timescale 1ns/1ps
`default_nettype none

interface load_bus_if #(
	parameter int ADDR_WIDTH = 25
) ();
	import cart_load_pkg::*;

	// one-cycle strobes, at most one of them per cycle
	logic                  cart_wr;
	logic                  code_wr;
	// byte address and data of the strobed word
	logic [ADDR_WIDTH-1:0] addr;
	load_word_t            word;
	// first cycle of a cartridge download
	logic                  cart_start;

	modport src  (output cart_wr, code_wr, addr, word, cart_start);
	modport sink (input  cart_wr, code_wr, addr, word, cart_start);

endinterface

`default_nettype wire

//--- source/cart_load_pkg.sv
// cartridge load package: word views, header offsets, cheat layout and quirk flags
`default_nettype none

package cart_load_pkg;

	////////////////////////////////////////
	// data types

	// one flash word, read whole or split into bytes
	// the cheat loader and SDRAM side use the whole word, header parsers the bytes
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] hi_byte;
			logic [7:0] lo_byte;
		} bytes;
	} load_word_t;

	// cheat code layout, msb is the one-cycle load strobe
	// integer fields stay big endian as the loader sends them
	typedef struct packed {
		logic        load;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// per-cartridge behaviour fixes
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic fmbusy;
	} quirk_flags_t;

	////////////////////////////////////////
	// offsets and constants

	// all-ones menu slot carries cheat files
	localparam logic [7:0] CODE_MENU_INDEX   = 8'hFF;
	// high replace half-word, the last one of a code
	localparam logic [3:0] CHEAT_LAST_OFFSET = 4'd14;

	// region letters in the ROM header
	localparam int unsigned HDR_REGION_A = 32'h1F0;
	localparam int unsigned HDR_REGION_B = 32'h1F2;
	// first word past the header
	localparam int unsigned HDR_END      = 32'h200;

	// serial number field, eight characters
	localparam int unsigned ID_FIRST  = 32'h182;
	localparam int unsigned ID_LAST   = 32'h18A;
	// ID is complete once this word arrives
	localparam int unsigned ID_DECIDE = 32'h18C;

	// light gun sensor delay for carts without a table entry
	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

endpackage

`default_nettype wire
